/* filelist.f */
+incdir+bench
verilog/dphyLaneTypesPkg.sv
verilog/dphyTimingPkg.sv
verilog/ppiTxPort.sv
verilog/laneController.sv
verilog/laneSerializer.sv
verilog/dphyDataLaneTx.sv
bench/dataLaneTb.sv

/* run.sh */
#!/bin/sh
# Builds the lane testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module dataLaneTb -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    cat build.log
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* bench/laneTasks.svh */
// Bench tasks for the data lane testbench; checks, HS burst driving, ULPS entry and exit, line symbol decoding

task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
        $display("[ERROR] %s got %h expected %h", name, got, exp);
        errors++;
    end
endtask

task automatic checkTrue(input logic ok, input string what);
    checks++;
    assert (ok === 1'b1)
    else
    begin
        $display("%s", what);
        errors++;
    end
endtask

task automatic reportTest(input string name, input int errsBefore);
    $display("%s finished with %0d errors", name, errors - errsBefore);
endtask

function automatic lineState_t symbolAt(input int idx);
    if (idx < 0 || idx >= symbols.size())
        return lineState_t'(3'd7);
    return symbols[idx];
endfunction

// Number of samples among len from start that equal s
function automatic int countMatches(input int start, input lineState_t s, input int len);
    int n;
    n = 0;
    for (int i = start; i < start + len; i++)
    begin
        if (symbolAt(i) == s)
            n++;
    end
    return n;
endfunction

// Waits for Stop, checks LP11 there, and returns on the next drive point
task automatic waitStop(input int maxCycles, input string what);
    int waited;
    waited = 0;
    do
    begin
        @(negedge ppi);
        waited++;
    end
    while (!stopstate && waited < maxCycles);
    checkTrue(stopstate, what);
    checkValue("line", 32'(line), 32'(LP11));
    @(posedge ppi);
    #2;
endtask

// Streams nWords random words; back-pressure comes only from txReadyHS
task automatic sendBurst(input int nWords);
    int cycles;
    logic moved;
    sentWords.delete();
    cycles = 0;
    txDataHS = WordWidth'($urandom);
    ppiReq.txRequestHS = 1'b1;
    while (sentWords.size() < nWords && cycles < nWords * (WordWidth + 4) + 64)
    begin
        @(negedge ppi);
        moved = txReadyHS;
        @(posedge ppi);
        #2;
        cycles++;
        if (moved)
        begin
            sentWords.push_back(txDataHS);
            txDataHS = WordWidth'($urandom);
            if (sentWords.size() == nWords)
                ppiReq.txRequestHS = 1'b0;
        end
    end
    ppiReq.txRequestHS = 1'b0;
    checkTrue(sentWords.size() == nWords, "Not every HS word was accepted before the timeout");
endtask

task automatic checkBurstLine();
    int idx;
    logic [7:0] sync;
    logic [WordWidth-1:0] word;
    logic lastBit;
    lineState_t trailSym;
    idx = 0;
    lastBit = 1'b0;
    while (symbolAt(idx) == LP11)
        idx++;
    checkTrue(idx > 0, "The burst did not start from LP11");
    checkValue("LP01 cycles", countMatches(idx, LP01, LPX), LPX);
    idx += LPX;
    checkValue("LP00 cycles", countMatches(idx, LP00, PREP), PREP);
    idx += PREP;
    checkValue("HS0 cycles", countMatches(idx, HS0, ZERO), ZERO);
    idx += ZERO;
    for (int i = 0; i < 8; i++)
        sync[i] = (symbolAt(idx + i) == HS1);
    checkValue("HS sync", 32'(sync), 32'(HS_SYNC));
    idx += 8;
    // Data bits go out LSB-first
    foreach (sentWords[w])
    begin
        for (int i = 0; i < WordWidth; i++)
            word[i] = (symbolAt(idx + i) == HS1);
        checkValue("HS data word", 32'(word), 32'(sentWords[w]));
        lastBit = sentWords[w][WordWidth-1];
        idx += WordWidth;
    end
    trailSym = lastBit ? HS0 : HS1;
    checkValue("trail cycles", countMatches(idx, trailSym, TRAIL), TRAIL);
    idx += TRAIL;
    checkValue("line after trail", 32'(symbolAt(idx)), 32'(LP11));
endtask

task automatic enterUlps();
    int idx;
    int waited;
    logic [7:0] cmd;
    lineState_t mark;
    symbols.delete();
    recording = 1'b1;
    ppiReq.txRequestEsc = 1'b1;
    ppiReq.txUlpsEsc = 1'b1;
    waited = 0;
    do
    begin
        @(negedge ppi);
        waited++;
    end
    while (ulpsActiveNot && waited < 4 * LPX + 16 * HALF + 10);
    recording = 1'b0;
    checkTrue(!ulpsActiveNot, "ulpsActiveNot did not fall after escape entry");
    idx = 0;
    while (symbolAt(idx) == LP11)
        idx++;
    checkValue("LP10 cycles", countMatches(idx, LP10, LPX), LPX);
    checkValue("LP00 cycles", countMatches(idx + LPX, LP00, LPX), LPX);
    checkValue("LP01 cycles", countMatches(idx + 2 * LPX, LP01, LPX), LPX);
    checkValue("LP00 cycles", countMatches(idx + 3 * LPX, LP00, LPX), LPX);
    idx += 4 * LPX;
    // Each command bit is a mark half followed by an LP00 half
    for (int i = 0; i < 8; i++)
    begin
        mark = symbolAt(idx);
        checkTrue(mark == LP10 || mark == LP01, "Escape command bit is not a mark");
        cmd[i] = (mark == LP10);
        checkValue("mark cycles", countMatches(idx, mark, HALF), HALF);
        checkValue("space cycles", countMatches(idx + HALF, LP00, HALF), HALF);
        idx += 2 * HALF;
    end
    checkValue("ULPS command", 32'(cmd), 32'(ULPS_COMMAND));
    repeat (4)
    begin
        @(negedge ppi);
        checkValue("line", 32'(line), 32'(LP00));
        checkValue("ulpsActiveNot", 32'(ulpsActiveNot), 32'd0);
    end
    @(posedge ppi);
    #2;
endtask

task automatic leaveUlps();
    int waited;
    ppiReq.txUlpsExit = 1'b1;
    waited = 0;
    do
    begin
        @(negedge ppi);
        waited++;
    end
    while (line != LP10 && waited < 5);
    checkValue("line", 32'(line), 32'(LP10));
    @(negedge ppi);
    checkValue("ulpsActiveNot", 32'(ulpsActiveNot), 32'd1);
    // Request still held, so the lane must stay in wake-up
    repeat (WAKE + 4) @(negedge ppi);
    checkValue("line", 32'(line), 32'(LP10));
    checkValue("stopstate", 32'(stopstate), 32'd0);
    @(posedge ppi);
    #2;
    ppiReq.txRequestEsc = 1'b0;
    ppiReq.txUlpsEsc = 1'b0;
    ppiReq.txUlpsExit = 1'b0;
    waitStop(10, "stopstate did not return after ULPS exit");
endtask

/* bench/dataLaneTb.sv */
// Testbench for the D-PHY data lane transmitter; runs init, HS bursts, a ULPS round trip and a shutdown
`timescale 1ns/1ps

module dataLaneTb;

    import dphyLaneTypesPkg::*;
    import dphyTimingPkg::*;

    localparam int WordWidth = WORD_WIDTH_DEFAULT;
    localparam int INITC = int'(T_INIT);
    localparam int LPX = int'(T_LPX);
    localparam int PREP = int'(T_HS_PREPARE);
    localparam int ZERO = int'(T_HS_ZERO);
    localparam int TRAIL = int'(T_HS_TRAIL);
    localparam int EXIT = int'(T_HS_EXIT);
    localparam int WAKE = int'(T_WAKEUP);
    localparam int HALF = int'(ESC_HALF);
    localparam int NUM_BURSTS = 4;
    localparam int MAX_WORDS = 6;

    logic                 ppi;
    logic                 hs_clk;
    ppiTxReq_t            ppiReq;
    logic [WordWidth-1:0] txDataHS;
    logic                 txReadyHS;
    logic                 stopstate;
    logic                 ulpsActiveNot;
    lineState_t           line;

    // Line symbols seen while recording at one per ppi cycle
    lineState_t           symbols[$];
    logic                 recording;
    logic [WordWidth-1:0] sentWords[$];
    int                   errors = 0;
    int                   checks = 0;

    dphyDataLaneTx #(
        .WordWidth(WordWidth)
    ) dut0 (
        .ppi(ppi),
        .hs_clk(hs_clk),
        .ppiReq(ppiReq),
        .txDataHS(txDataHS),
        .txReadyHS(txReadyHS),
        .stopstate(stopstate),
        .ulpsActiveNot(ulpsActiveNot),
        .line(line)
    );

    `include "laneTasks.svh"

    initial
    begin
        ppi = 1'b0;
        forever #10 ppi = ~ppi;
    end

    // Line decoder sampling in the middle of each cycle
    always @(negedge ppi)
    begin
        if (recording)
            symbols.push_back(line);
    end

    // Ready may only be offered while the lane is in HS
    always @(negedge ppi)
    begin
        if (hs_clk && txReadyHS)
        begin
            assert (line == HS0 || line == HS1)
            else
            begin
                $display("txReadyHS was high while the lane was not in a burst");
                errors++;
            end
        end
    end

    function automatic int expectedCycles();
        int burst;
        burst = 8 + LPX + PREP + ZERO + 8 + MAX_WORDS * WordWidth + TRAIL + EXIT + 10;
        return INITC + 20 + NUM_BURSTS * burst + 4 * LPX + 16 * HALF + WAKE + 40 + 60;
    endfunction

    // Watchdog
    initial
    begin
        int limitCycles;
        limitCycles = 2 * expectedCycles();
        repeat (limitCycles) @(posedge ppi);
        $display("Timeout, the run did not finish within %0d cycles", limitCycles);
        $display("test failed");
        $finish;
    end

    initial
    begin
        int errsBefore;
        int b;
        int gap;
        int waited;
        void'($urandom(26649));
        hs_clk = 1'b0;
        ppiReq = '0;
        txDataHS = '0;
        recording = 1'b0;
        repeat (2) @(posedge ppi);
        #2;
        hs_clk = 1'b1;

        errsBefore = errors;
        @(negedge ppi);
        checkValue("txReadyHS", 32'(txReadyHS), 32'd0);
        checkValue("stopstate", 32'(stopstate), 32'd0);
        checkValue("ulpsActiveNot", 32'(ulpsActiveNot), 32'd1);
        checkValue("line", 32'(line), 32'(LP11));
        @(posedge ppi);
        #2;
        ppiReq.enable = 1'b1;
        waitStop(INITC + 8, "stopstate did not rise after init");
        reportTest("reset and init", errsBefore);

        for (b = 0; b < NUM_BURSTS; b++)
        begin
            errsBefore = errors;
            gap = $urandom_range(7, 0);
            repeat (gap + 1) @(posedge ppi);
            #2;
            symbols.delete();
            recording = 1'b1;
            sendBurst($urandom_range(MAX_WORDS, 1));
            waitStop(TRAIL + EXIT + 3 * WordWidth + 10, "stopstate did not return after a burst");
            recording = 1'b0;
            checkBurstLine();
            reportTest($sformatf("burst %0d", b), errsBefore);
        end

        errsBefore = errors;
        enterUlps();
        leaveUlps();
        reportTest("ulps round trip", errsBefore);

        // Shutdown in the middle of the data phase
        errsBefore = errors;
        ppiReq.txRequestHS = 1'b1;
        waited = 0;
        do
        begin
            @(negedge ppi);
            waited++;
        end
        while (!txReadyHS && waited < LPX + PREP + ZERO + 8);
        checkTrue(txReadyHS, "txReadyHS never rose for the shutdown burst");
        // Ready first rises on the first HS0 cycle, so this lands inside the first data word
        repeat (ZERO + 8 + WordWidth / 2) @(posedge ppi);
        #2;
        ppiReq.enable = 1'b0;
        repeat (2) @(posedge ppi);
        @(negedge ppi);
        checkValue("stopstate", 32'(stopstate), 32'd0);
        checkValue("txReadyHS", 32'(txReadyHS), 32'd0);
        checkValue("line", 32'(line), 32'(LP11));
        reportTest("shutdown mid-burst", errsBefore);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* verilog/dphyDataLaneTx.sv */
// D-PHY master data lane transmitter top; joins the PPI port, lane FSM and serializer and sets their timing
`timescale 1ns/1ps

module dphyDataLaneTx #(
    parameter int          WordWidth    = dphyTimingPkg::WORD_WIDTH_DEFAULT,
    parameter logic [15:0] T_INIT       = dphyTimingPkg::T_INIT,
    parameter logic [15:0] T_LPX        = dphyTimingPkg::T_LPX,
    parameter logic [15:0] T_HS_PREPARE = dphyTimingPkg::T_HS_PREPARE,
    parameter logic [15:0] T_HS_ZERO    = dphyTimingPkg::T_HS_ZERO,
    parameter logic [15:0] T_HS_TRAIL   = dphyTimingPkg::T_HS_TRAIL,
    parameter logic [15:0] T_HS_EXIT    = dphyTimingPkg::T_HS_EXIT,
    parameter logic [15:0] T_WAKEUP     = dphyTimingPkg::T_WAKEUP,
    parameter logic [15:0] ESC_HALF     = dphyTimingPkg::ESC_HALF
) (
    input  logic                        ppi,
    input  logic                        hs_clk,
    input  dphyLaneTypesPkg::ppiTxReq_t  ppiReq,
    input  logic [WordWidth-1:0]        txDataHS,
    output logic                        txReadyHS,
    output logic                        stopstate,
    output logic                        ulpsActiveNot,
    output dphyLaneTypesPkg::lineState_t line
);

    import dphyLaneTypesPkg::*;

    ppiTxReq_t            req;
    laneState_t           laneState;
    logic                 hsAccept;
    logic                 bufValid;
    logic [WordWidth-1:0] bufWord;
    logic                 wordTake;
    logic                 serialDone;

    ppiTxPort #(
        .WordWidth(WordWidth)
    ) txPort (
        .ppi(ppi),
        .hs_clk(hs_clk),
        .ppiReq(ppiReq),
        .txDataHS(txDataHS),
        .hsAccept(hsAccept),
        .wordTake(wordTake),
        .req(req),
        .txReadyHS(txReadyHS),
        .bufValid(bufValid),
        .bufWord(bufWord)
    );

    laneController #(
        .T_INIT(T_INIT),
        .T_LPX(T_LPX),
        .T_HS_PREPARE(T_HS_PREPARE),
        .T_HS_ZERO(T_HS_ZERO),
        .T_HS_TRAIL(T_HS_TRAIL),
        .T_HS_EXIT(T_HS_EXIT),
        .T_WAKEUP(T_WAKEUP)
    ) controller (
        .ppi(ppi),
        .hs_clk(hs_clk),
        .req(req),
        .bufValid(bufValid),
        .serialDone(serialDone),
        .laneState(laneState),
        .hsAccept(hsAccept),
        .stopstate(stopstate),
        .ulpsActiveNot(ulpsActiveNot)
    );

    laneSerializer #(
        .WordWidth(WordWidth),
        .T_LPX(T_LPX),
        .ESC_HALF(ESC_HALF)
    ) serializer (
        .ppi(ppi),
        .hs_clk(hs_clk),
        .laneState(laneState),
        .bufValid(bufValid),
        .bufWord(bufWord),
        .wordTake(wordTake),
        .serialDone(serialDone),
        .line(line)
    );

endmodule

/* verilog/laneSerializer.sv */
// Lane output stage; shifts out sync, HS words and escape command bits and maps the FSM state to a line symbol
`timescale 1ns/1ps

module laneSerializer #(
    parameter int          WordWidth = dphyTimingPkg::WORD_WIDTH_DEFAULT,
    parameter logic [15:0] T_LPX     = dphyTimingPkg::T_LPX,
    parameter logic [15:0] ESC_HALF  = dphyTimingPkg::ESC_HALF
) (
    input  logic                        ppi,
    input  logic                        hs_clk,
    input  dphyLaneTypesPkg::laneState_t laneState,
    input  logic                        bufValid,
    input  logic [WordWidth-1:0]        bufWord,
    output logic                        wordTake,
    output logic                        serialDone,
    output dphyLaneTypesPkg::lineState_t line
);

    import dphyLaneTypesPkg::*;
    import dphyTimingPkg::*;

    localparam logic [15:0] LPX2 = 16'(2 * T_LPX);
    localparam logic [15:0] LPX3 = 16'(3 * T_LPX);
    localparam logic [4:0] WORD_BITS = 5'(WordWidth);

    logic [WordWidth-1:0] shiftReg;
    logic [4:0]           bitCnt;
    logic [15:0]          phaseCnt;
    logic [15:0]          halfCnt;
    logic                 spaceHalf;
    logic                 lastBit;
    logic                 hsBit;
    logic                 halfEnd;

    // Shifter empty or on its last bit, so the next word can follow without a gap
    assign wordTake = (laneState == HsData) && bufValid && (bitCnt <= 5'd1);

    // When starved the line repeats the last bit sent
    assign hsBit = (bitCnt != 5'd0) ? shiftReg[0] : lastBit;
    assign halfEnd = (halfCnt == ESC_HALF - 16'd1);

    always_comb
    begin
        case (laneState)
            HsData:     serialDone = (bitCnt <= 5'd1);
            EscCommand: serialDone = (bitCnt == 5'd0);
            default:    serialDone = 1'b0;
        endcase
    end

    always_comb
    begin
        case (laneState)
            HsStart:    line = (phaseCnt < T_LPX) ? LP01 : LP00;
            HsZero:     line = HS0;
            HsData:     line = hsBit ? HS1 : HS0;
            HsTrail:    line = lastBit ? HS0 : HS1;
            EscEntry:
            begin
                // LP10, LP00, LP01, LP00
                if (phaseCnt < T_LPX)
                    line = LP10;
                else if (phaseCnt < LPX2)
                    line = LP00;
                else if (phaseCnt < LPX3)
                    line = LP01;
                else
                    line = LP00;
            end
            EscCommand:
            begin
                if (bitCnt == 5'd0 || spaceHalf)
                    line = LP00;
                else
                    line = shiftReg[0] ? MARK1 : MARK0;
            end
            Ulps:       line = LP00;
            UlpsWake:   line = MARK1;
            default:    line = LP11;
        endcase
    end

    // Counters and bit history
    always_ff @(posedge ppi or negedge hs_clk)
    begin
        if (!hs_clk)
        begin
            bitCnt <= 5'd0;
            phaseCnt <= 16'd0;
            halfCnt <= 16'd0;
            spaceHalf <= 1'b0;
            lastBit <= 1'b0;
        end
        else
        begin
            case (laneState)
                HsStart:
                begin
                    phaseCnt <= phaseCnt + 16'd1;
                end
                HsZero:
                begin
                    // Sync byte queued behind the zero period
                    bitCnt <= 5'd8;
                    lastBit <= 1'b0;
                end
                HsData:
                begin
                    if (bitCnt != 5'd0)
                        lastBit <= shiftReg[0];
                    if (wordTake)
                        bitCnt <= WORD_BITS;
                    else if (bitCnt != 5'd0)
                        bitCnt <= bitCnt - 5'd1;
                end
                EscEntry:
                begin
                    phaseCnt <= phaseCnt + 16'd1;
                    bitCnt <= 5'd8;
                    halfCnt <= 16'd0;
                    spaceHalf <= 1'b0;
                end
                EscCommand:
                begin
                    if (bitCnt != 5'd0)
                    begin
                        if (halfEnd)
                        begin
                            halfCnt <= 16'd0;
                            spaceHalf <= !spaceHalf;
                            // A bit is over after its LP00 half
                            if (spaceHalf)
                                bitCnt <= bitCnt - 5'd1;
                        end
                        else
                        begin
                            halfCnt <= halfCnt + 16'd1;
                        end
                    end
                end
                default:
                begin
                    phaseCnt <= 16'd0;
                    bitCnt <= 5'd0;
                end
            endcase
        end
    end

    // Payload shifter
    always_ff @(posedge ppi)
    begin
        case (laneState)
            HsZero:
                shiftReg <= WordWidth'(HS_SYNC);
            HsData:
            begin
                if (wordTake)
                    shiftReg <= bufWord;
                else if (bitCnt != 5'd0)
                    shiftReg <= shiftReg >> 1;
            end
            EscEntry:
                shiftReg <= WordWidth'(ULPS_COMMAND);
            EscCommand:
            begin
                if (bitCnt != 5'd0 && halfEnd && spaceHalf)
                    shiftReg <= shiftReg >> 1;
            end
            default:
                shiftReg <= shiftReg;
        endcase
    end

endmodule

/* verilog/laneController.sv */
// Lane FSM with its single down-counter; sequences init, HS bursts, ULPS entry and wake-up
`timescale 1ns/1ps

module laneController #(
    parameter logic [15:0] T_INIT       = dphyTimingPkg::T_INIT,
    parameter logic [15:0] T_LPX        = dphyTimingPkg::T_LPX,
    parameter logic [15:0] T_HS_PREPARE = dphyTimingPkg::T_HS_PREPARE,
    parameter logic [15:0] T_HS_ZERO    = dphyTimingPkg::T_HS_ZERO,
    parameter logic [15:0] T_HS_TRAIL   = dphyTimingPkg::T_HS_TRAIL,
    parameter logic [15:0] T_HS_EXIT    = dphyTimingPkg::T_HS_EXIT,
    parameter logic [15:0] T_WAKEUP     = dphyTimingPkg::T_WAKEUP
) (
    input  logic                        ppi,
    input  logic                        hs_clk,
    input  dphyLaneTypesPkg::ppiTxReq_t  req,
    input  logic                        bufValid,
    input  logic                        serialDone,
    output dphyLaneTypesPkg::laneState_t laneState,
    output logic                        hsAccept,
    output logic                        stopstate,
    output logic                        ulpsActiveNot
);

    import dphyLaneTypesPkg::*;

    laneState_t  nextState;
    logic [15:0] timer;
    logic        timeUp;

    // Cycles spent in a state; untimed states get one so the counter sits at zero
    function automatic logic [15:0] stateLength(input laneState_t s);
        logic [15:0] len;
        case (s)
            Init:     len = T_INIT;
            HsStart:  len = 16'(T_LPX + T_HS_PREPARE);
            HsZero:   len = T_HS_ZERO;
            HsTrail:  len = T_HS_TRAIL;
            HsExit:   len = T_HS_EXIT;
            EscEntry: len = 16'(4 * T_LPX);
            UlpsWake: len = T_WAKEUP;
            default:  len = 16'd1;
        endcase
        return len;
    endfunction

    assign timeUp = (timer == 16'd0);

    // The buffer may fill during HS0 so the first word is ready after sync
    assign hsAccept = (laneState == HsZero) || (laneState == HsData);
    assign stopstate = (laneState == Stop);

    always_comb
    begin
        nextState = laneState;
        if (!req.enable)
        begin
            // Shutdown wins from every state
            nextState = Off;
        end
        else
        begin
            case (laneState)
                Off:
                begin
                    nextState = Init;
                end
                Init:
                begin
                    if (timeUp)
                        nextState = Stop;
                end
                Stop:
                begin
                    if (req.txRequestHS)
                        nextState = HsStart;
                    else if (req.txRequestEsc && req.txUlpsEsc)
                        nextState = EscEntry;
                end
                HsStart:
                begin
                    if (timeUp)
                        nextState = HsZero;
                end
                HsZero:
                begin
                    if (timeUp)
                        nextState = HsData;
                end
                HsData:
                begin
                    // Host done, nothing buffered and the shifter on its last bit or idle
                    if (!req.txRequestHS && !bufValid && serialDone)
                        nextState = HsTrail;
                end
                HsTrail:
                begin
                    if (timeUp)
                        nextState = HsExit;
                end
                HsExit:
                begin
                    if (timeUp)
                        nextState = Stop;
                end
                EscEntry:
                begin
                    if (timeUp)
                        nextState = EscCommand;
                end
                EscCommand:
                begin
                    if (serialDone)
                        nextState = Ulps;
                end
                Ulps:
                begin
                    if (req.txUlpsExit)
                        nextState = UlpsWake;
                end
                UlpsWake:
                begin
                    // Hold mark-1 for the full wake-up, then wait for the host to let go
                    if (timeUp && !req.txRequestEsc)
                        nextState = Stop;
                end
                default:
                begin
                    nextState = Off;
                end
            endcase
        end
    end

    always_ff @(posedge ppi or negedge hs_clk)
    begin
        if (!hs_clk)
        begin
            laneState <= Off;
            timer <= 16'd0;
            ulpsActiveNot <= 1'b1;
        end
        else
        begin
            laneState <= nextState;
            if (nextState != laneState)
                timer <= stateLength(nextState) - 16'd1;
            else if (!timeUp)
                timer <= timer - 16'd1;
            // Lags the state by one cycle on entry to and exit from ULPS
            ulpsActiveNot <= (laneState != Ulps);
        end
    end

endmodule

/* verilog/ppiTxPort.sv */
// PPI input stage of the lane; registers the requests and buffers one HS word behind the ready handshake
`timescale 1ns/1ps

module ppiTxPort #(
    parameter int WordWidth = dphyTimingPkg::WORD_WIDTH_DEFAULT
) (
    input  logic                       ppi,
    input  logic                       hs_clk,
    input  dphyLaneTypesPkg::ppiTxReq_t ppiReq,
    input  logic [WordWidth-1:0]       txDataHS,
    input  logic                       hsAccept,
    input  logic                       wordTake,
    output dphyLaneTypesPkg::ppiTxReq_t req,
    output logic                       txReadyHS,
    output logic                       bufValid,
    output logic [WordWidth-1:0]       bufWord
);

    logic wordIn;

    // Room for a word only while the controller has the data phase open
    assign txReadyHS = hsAccept && !bufValid;

    // Host word moves on the edge where request and ready meet
    assign wordIn = ppiReq.txRequestHS && txReadyHS;

    // Requests reach the controller one cycle late
    always_ff @(posedge ppi or negedge hs_clk)
    begin
        if (!hs_clk)
        begin
            req <= '0;
        end
        else
        begin
            req <= ppiReq;
        end
    end

    // Buffer occupancy
    always_ff @(posedge ppi or negedge hs_clk)
    begin
        if (!hs_clk)
        begin
            bufValid <= 1'b0;
        end
        else if (!hsAccept)
        begin
            // Leftover word is dropped when the burst closes or the lane shuts down
            bufValid <= 1'b0;
        end
        else if (wordIn)
        begin
            bufValid <= 1'b1;
        end
        else if (wordTake)
        begin
            bufValid <= 1'b0;
        end
    end

    // Word storage, refilled while the serializer shifts the previous word
    always_ff @(posedge ppi)
    begin
        if (wordIn)
        begin
            bufWord <= txDataHS;
        end
    end

endmodule

/* verilog/dphyTimingPkg.sv */
// Default lane timing in ppi cycles and the fixed HS and escape codes used by the lane and its bench
package dphyTimingPkg;

    // Power-up time in LP11 before the first Stop
    localparam logic [15:0] T_INIT = 16'd32;

    // One LP symbol during start-up and escape entry
    localparam logic [15:0] T_LPX = 16'd4;

    // HS start-up, LP00 then HS0
    localparam logic [15:0] T_HS_PREPARE = 16'd5;
    localparam logic [15:0] T_HS_ZERO = 16'd12;

    // HS end of burst
    localparam logic [15:0] T_HS_TRAIL = 16'd8;
    localparam logic [15:0] T_HS_EXIT = 16'd10;

    // Mark-1 time when leaving ULPS
    localparam logic [15:0] T_WAKEUP = 16'd50;

    // Half of one escape bit, the mark and the following LP00 each last this long
    localparam logic [15:0] ESC_HALF = 16'd2;

    // Codes, both sent LSB-first
    localparam logic [7:0] HS_SYNC = 8'hB8;
    localparam logic [7:0] ULPS_COMMAND = 8'h78;

    localparam int WORD_WIDTH_DEFAULT = 8;

endpackage

/* verilog/dphyLaneTypesPkg.sv */
// Line symbols, lane FSM states and the PPI request bundle shared by the D-PHY lane design and its bench
package dphyLaneTypesPkg;

    // Symbols a single data lane can put on its two wires
    typedef enum logic [2:0]
    {
        LP00 = 3'd0,
        LP01 = 3'd1,
        LP10 = 3'd2,
        LP11 = 3'd3,
        HS0  = 3'd4,
        HS1  = 3'd5
    } lineState_t;

    // Spaced-one-hot escape marks
    localparam lineState_t MARK1 = LP10;
    localparam lineState_t MARK0 = LP01;

    // Lane FSM states
    typedef enum logic [3:0]
    {
        Off        = 4'd0,
        Init       = 4'd1,
        Stop       = 4'd2,
        HsStart    = 4'd3,
        HsZero     = 4'd4,
        HsData     = 4'd5,
        HsTrail    = 4'd6,
        HsExit     = 4'd7,
        EscEntry   = 4'd8,
        EscCommand = 4'd9,
        Ulps       = 4'd10,
        UlpsWake   = 4'd11
    } laneState_t;

    // Request bits from the protocol layer
    typedef struct packed
    {
        logic enable;
        logic txRequestHS;
        logic txRequestEsc;
        logic txUlpsEsc;
        logic txUlpsExit;
    } ppiTxReq_t;

endpackage
